// ==== bench/muldiv_input.txt ====
# op tag rs1 rs2 expected, all hex
# op: 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 DIV, 5 DIVU, 6 REM, 7 REMU
0 0 00000007 00000006 0000002a
0 1 ffffffff 00000005 fffffffb
0 2 80000000 ffffffff 80000000
0 3 12345678 00000010 23456780
0 4 deadbeef 00000001 deadbeef
1 5 80000000 80000000 40000000
1 6 ffffffff ffffffff 00000000
1 7 7fffffff 80000000 c0000000
1 8 fffffffe 00000003 ffffffff
2 9 ffffffff ffffffff ffffffff
2 a 80000000 00000002 ffffffff
2 b 7fffffff ffffffff 7ffffffe
3 c ffffffff ffffffff fffffffe
3 d 80000000 00000002 00000001

# divides, including zero divisors and the signed overflow pair
4 0 00000014 fffffffa fffffffd
4 1 80000000 ffffffff 80000000
4 2 00000007 00000000 ffffffff
5 3 ffffffff 00000010 0fffffff
5 4 00000007 00000000 ffffffff
6 5 ffffffec 00000006 fffffffe
6 6 80000000 ffffffff 00000000
6 7 fffffff9 00000000 fffffff9
7 8 ffffffff 00000010 0000000f
7 9 00000007 00000000 00000007

// ==== muldiv.f ====
logic/muldiv_pkg.sv
logic/exec_if.sv
logic/pp_mul32.sv
logic/div32.sv
logic/muldiv_port.sv
logic/muldiv_top.sv
bench/clk_gen.sv
bench/muldiv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module muldiv_tb -f muldiv.f > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vmuldiv_tb > sim.log 2>&1 || echo "simulator exited with an error"
grep -q "^Result: PASSED$" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== bench/muldiv_tb.sv ====
`timescale 1ns/1ps
// Testbench for the multiply/divide unit that checks file and random vectors by tag
module muldiv_tb import muldiv_pkg::*; ();
    localparam int TAGS       = 1 << TAG_W;
    localparam int WAIT_LIMIT = 400;

    logic             CLK;
    logic             nRST;
    logic             req;
    muldiv_op_e       op;
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  rs1;
    logic [XLEN-1:0]  rs2;
    logic             ready;
    logic             result_valid;
    logic [XLEN-1:0]  result;
    logic [TAG_W-1:0] result_tag;

    // Scoreboard with one entry per tag
    logic             pending [TAGS];
    logic             is_mul  [TAGS];
    logic [XLEN-1:0]  exp_val [TAGS];
    int               due     [TAGS];
    int               cyc = 0;
    integer           seed;
    logic [TAG_W-1:0] next_tag;

    clk_gen u_clk (
        .CLK  (CLK),
        .nRST (nRST)
    );

    muldiv_top dut0 (.*);

    always @(posedge CLK) begin
        cyc <= cyc + 1;
    end

    // Reference model in 64-bit arithmetic
    function automatic logic [XLEN-1:0] expected_result(
        input muldiv_op_e      o,
        input logic [XLEN-1:0] x,
        input logic [XLEN-1:0] y
    );
        longint          sx;
        longint          sy;
        longint unsigned ux;
        longint unsigned uy;
        longint          p;
        sx = $signed(x);
        sy = $signed(y);
        ux = x;
        uy = y;
        case (o)
            MUL:     p = sx * sy;
            MULH:    p = (sx * sy) >>> XLEN;
            MULHSU:  p = (sx * longint'(uy)) >>> XLEN;
            MULHU:   p = (ux * uy) >> XLEN;
            // Most negative over -1 falls out of the wide divide
            DIV:     p = (sy == 0) ? -1 : sx / sy;
            DIVU:    p = (uy == 0) ? -1 : longint'(ux / uy);
            REM:     p = (sy == 0) ? sx : sx % sy;
            default: p = (uy == 0) ? sx : longint'(ux % uy);
        endcase
        expected_result = p[XLEN-1:0];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_result(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("mismatch result (tag %h): got %h, expected %h",
                                result_tag, got, want));
        end
    endtask

    task automatic check_tag(input logic [TAG_W-1:0] got, input logic [TAG_W-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("mismatch result_tag: got %h, expected %h", got, want));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, want));
        end
    endtask

    // Wait for the falling edge and check what the DUT returned
    task automatic advance_cycle();
        logic div_open;
        @(negedge CLK);
        for (int t = 0; t < TAGS; t++) begin
            if (pending[t] && is_mul[t] && due[t] == cyc) begin
                if (!result_valid) begin
                    abort_run($sformatf("multiply with tag %h gave no result on time", t));
                end
                check_tag(result_tag, TAG_W'(t));
            end
        end
        if (result_valid) begin
            if (!pending[result_tag]) begin
                abort_run($sformatf("result with tag %h arrived with nothing outstanding",
                                    result_tag));
            end
            if (is_mul[result_tag] && due[result_tag] != cyc) begin
                abort_run($sformatf("multiply with tag %h returned early", result_tag));
            end
            check_result(result, exp_val[result_tag]);
            pending[result_tag] = 1'b0;
        end
        div_open = 1'b0;
        for (int t = 0; t < TAGS; t++) begin
            div_open = div_open | (pending[t] & !is_mul[t]);
        end
        check_flag("ready", ready, !div_open);
    endtask

    // Present a request until taken and hold it back while its tag is in use
    task automatic issue(
        input muldiv_op_e       o,
        input logic [TAG_W-1:0] t,
        input logic [XLEN-1:0]  x,
        input logic [XLEN-1:0]  y,
        input logic [XLEN-1:0]  want
    );
        for (int n = 0; n < WAIT_LIMIT; n++) begin
            advance_cycle();
            req = !pending[t];
            op  = o;
            tag = t;
            rs1 = x;
            rs2 = y;
            if (!pending[t] && (!o[OP_W-1] || ready)) begin
                pending[t] = 1'b1;
                is_mul[t]  = !o[OP_W-1];
                exp_val[t] = want;
                // Port register adds one cycle to the multiplier
                due[t]     = cyc + MUL_LATENCY + 1;
                return;
            end
        end
        abort_run($sformatf("request with tag %h was never accepted", t));
    endtask

    task automatic issue_random(input muldiv_op_e o);
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        x = $random(seed);
        y = $random(seed);
        // Some tiny or zero divisors and the signed overflow pair
        if (y[XLEN-1:XLEN-3] == 3'b000) begin
            y = y & 32'h3;
        end
        if (x[4:0] == 5'h00) begin
            x = 32'h8000_0000;
            y = 32'hffff_ffff;
        end
        for (int k = 0; k < TAGS && pending[next_tag]; k++) begin
            next_tag = next_tag + 1'b1;
        end
        issue(o, next_tag, x, y, expected_result(o, x, y));
        next_tag = next_tag + 1'b1;
    endtask

    task automatic drain_results();
        logic open;
        for (int n = 0; n < WAIT_LIMIT; n++) begin
            open = 1'b0;
            for (int t = 0; t < TAGS; t++) begin
                open = open | pending[t];
            end
            if (!open) begin
                return;
            end
            advance_cycle();
            req = 1'b0;
        end
        abort_run("results still outstanding after the timeout");
    endtask

    initial begin
        int               fd;
        string            line;
        logic [OP_W-1:0]  f_op;
        logic [TAG_W-1:0] f_tag;
        logic [XLEN-1:0]  f_a;
        logic [XLEN-1:0]  f_b;
        logic [XLEN-1:0]  f_want;
        seed     = 60009;
        next_tag = '0;
        req      = 1'b0;
        op       = MUL;
        tag      = '0;
        rs1      = '0;
        rs2      = '0;
        for (int t = 0; t < TAGS; t++) begin
            pending[t] = 1'b0;
            is_mul[t]  = 1'b0;
            exp_val[t] = '0;
            due[t]     = 0;
        end

        for (int n = 0; n < WAIT_LIMIT; n++) begin
            @(posedge CLK);
            if (nRST === 1'b1) begin
                break;
            end
        end
        if (nRST !== 1'b1) begin
            abort_run("reset was never released");
        end
        @(negedge CLK);
        check_flag("ready", ready, 1'b1);
        check_flag("result_valid", result_valid, 1'b0);

        fd = $fopen("bench/muldiv_input.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/muldiv_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h %h %h", f_op, f_tag, f_a, f_b, f_want) != 5) begin
                    abort_run({"malformed vector line: ", line});
                end
                issue(muldiv_op_e'(f_op), f_tag, f_a, f_b, f_want);
            end
        end
        $fclose(fd);
        drain_results();

        // Divide starved by a steady multiply stream, then a second divide held off
        issue_random(DIV);
        for (int n = 0; n < 45; n++) begin
            issue_random(muldiv_op_e'(OP_W'(n % 4)));
        end
        issue_random(REM);
        drain_results();

        for (int n = 0; n < 200; n++) begin
            issue_random(muldiv_op_e'(OP_W'($random(seed))));
        end
        drain_results();

        $display("Result: PASSED");
        $finish;
    end
endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps
// Testbench clock and reset source with a 40 ns period and reset held for 16 cycles
module clk_gen (
    output logic CLK,
    output logic nRST
);
    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Release lands on a falling edge
    initial begin
        nRST = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end
endmodule

// ==== logic/muldiv_top.sv ====
`timescale 1ns/1ps
// Multiply/divide execution unit joining the result port to the multiplier and divider
module muldiv_top import muldiv_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             req,
    input  muldiv_op_e       op,
    input  logic [TAG_W-1:0] tag,
    input  logic [XLEN-1:0]  rs1,
    input  logic [XLEN-1:0]  rs2,
    output logic             ready,
    output logic             result_valid,
    output logic [XLEN-1:0]  result,
    output logic [TAG_W-1:0] result_tag
);
    // One bundle per execution unit
    exec_if mul_bus ();
    exec_if div_bus ();

    // Each bundle is seen twice, once to issue and once to collect
    muldiv_port u_port (
        .CLK          (CLK),
        .nRST         (nRST),
        .req          (req),
        .op           (op),
        .tag          (tag),
        .rs1          (rs1),
        .rs2          (rs2),
        .ready        (ready),
        .result_valid (result_valid),
        .result       (result),
        .result_tag   (result_tag),
        .mul_bus      (mul_bus),
        .div_bus      (div_bus),
        .mul_res      (mul_bus),
        .div_res      (div_bus)
    );

    pp_mul32 u_mul (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (mul_bus)
    );

    div32 u_div (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (div_bus)
    );

endmodule

// ==== logic/muldiv_port.sv ====
`timescale 1ns/1ps
// Request steering and fixed-priority result arbitration for the multiply/divide unit
module muldiv_port import muldiv_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             req,
    input  muldiv_op_e       op,
    input  logic [TAG_W-1:0] tag,
    input  logic [XLEN-1:0]  rs1,
    input  logic [XLEN-1:0]  rs2,
    output logic             ready,
    output logic             result_valid,
    output logic [XLEN-1:0]  result,
    output logic [TAG_W-1:0] result_tag,
    exec_if.issuer           mul_bus,
    exec_if.issuer           div_bus,
    exec_if.arbiter          mul_res,
    exec_if.arbiter          div_res
);
    logic is_div;
    logic win_valid;

    assign is_div = op[OP_W-1];

    // Divides wait for the divider to drain
    assign ready = !div_bus.busy;

    assign mul_bus.start = req && !is_div;
    assign mul_bus.a     = rs1;
    assign mul_bus.b     = rs2;
    assign mul_bus.mode  = op[MODE_W-1:0];
    assign mul_bus.tag   = tag;

    assign div_bus.start = req && is_div && !div_bus.busy;
    assign div_bus.a     = rs1;
    assign div_bus.b     = rs2;
    assign div_bus.mode  = op[MODE_W-1:0];
    assign div_bus.tag   = tag;

    // Multiplier pipeline cannot stall so it always wins
    assign mul_res.grant = mul_res.done;
    assign div_res.grant = div_res.done && !mul_res.done;
    assign win_valid     = mul_res.done || div_res.grant;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= win_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (mul_res.done) begin
            result     <= mul_res.result;
            result_tag <= mul_res.result_tag;
        end else if (div_res.grant) begin
            result     <= div_res.result;
            result_tag <= div_res.result_tag;
        end
    end

endmodule

// ==== logic/div32.sv ====
`timescale 1ns/1ps
// Iterative restoring divider following the RISC-V divide rules
module div32 import muldiv_pkg::*; (
    input logic  CLK,
    input logic  nRST,
    exec_if.unit bus
);
    logic                 busy_r;
    logic                 done_r;
    logic [DIV_CNT_W-1:0] cnt;
    logic                 accept;
    logic                 last_step;
    logic                 op_signed;
    logic                 op_rem;
    logic                 a_neg;
    logic                 b_neg;
    logic [XLEN-1:0]      a_mag;
    logic [XLEN-1:0]      b_mag;
    logic [XLEN-1:0]      rem_r;
    logic [XLEN-1:0]      quo_r;
    logic [XLEN-1:0]      dvsr_r;
    logic                 neg_q_r;
    logic                 neg_r_r;
    logic                 rem_sel_r;
    logic [TAG_W-1:0]     tag_r;
    logic [XLEN-1:0]      result_r;
    logic [XLEN:0]        shifted;
    logic [XLEN:0]        diff;
    logic [XLEN-1:0]      quo_fix;
    logic [XLEN-1:0]      rem_fix;

    assign accept    = bus.start && !busy_r;
    assign last_step = (cnt == DIV_CNT_W'(DIV_STEPS));

    // Signed for DIV and REM only
    assign op_signed = (bus.mode == MODE_W'(DIV)) || (bus.mode == MODE_W'(REM));
    assign op_rem    = (bus.mode == MODE_W'(REM)) || (bus.mode == MODE_W'(REMU));
    assign a_neg     = op_signed && bus.a[XLEN-1];
    assign b_neg     = op_signed && bus.b[XLEN-1];
    assign a_mag     = a_neg ? -bus.a : bus.a;
    assign b_mag     = b_neg ? -bus.b : bus.b;

    // Shift in the next dividend bit and try the subtract
    assign shifted = {rem_r, quo_r[XLEN-1]};
    assign diff    = shifted - {1'b0, dvsr_r};

    assign quo_fix = neg_q_r ? -quo_r : quo_r;
    assign rem_fix = neg_r_r ? -rem_r : rem_r;

    // Busy from accept until the result is granted
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_r <= 1'b0;
            done_r <= 1'b0;
            cnt    <= '0;
        end else if (accept) begin
            busy_r <= 1'b1;
            done_r <= 1'b0;
            cnt    <= '0;
        end else if (done_r) begin
            if (bus.grant) begin
                busy_r <= 1'b0;
                done_r <= 1'b0;
            end
        end else if (busy_r) begin
            if (last_step) begin
                done_r <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            rem_r     <= '0;
            quo_r     <= a_mag;
            dvsr_r    <= b_mag;
            // Zero divisor keeps the all-ones quotient unsigned
            neg_q_r   <= (a_neg ^ b_neg) && (bus.b != '0);
            neg_r_r   <= a_neg;
            rem_sel_r <= op_rem;
            tag_r     <= bus.tag;
        end else if (busy_r && !done_r) begin
            if (last_step) begin
                // Overflow case comes out as 0x80000000 rem 0 on its own
                result_r <= rem_sel_r ? rem_fix : quo_fix;
            end else if (!diff[XLEN]) begin
                rem_r <= diff[XLEN-1:0];
                quo_r <= {quo_r[XLEN-2:0], 1'b1};
            end else begin
                rem_r <= shifted[XLEN-1:0];
                quo_r <= {quo_r[XLEN-2:0], 1'b0};
            end
        end
    end

    assign bus.done       = done_r;
    assign bus.result     = result_r;
    assign bus.result_tag = tag_r;
    assign bus.busy       = busy_r;

endmodule

// ==== logic/pp_mul32.sv ====
`timescale 1ns/1ps
// Four-stage radix-4 Booth multiplier with carry-save reduction and high/low word select
module pp_mul32 import muldiv_pkg::*; (
    input logic  CLK,
    input logic  nRST,
    exec_if.unit bus
);
    logic [MUL_LATENCY-1:0] vld;
    logic [TAG_W-1:0]       tag_p  [MUL_LATENCY];
    logic [MODE_W-1:0]      mode_p [MUL_LATENCY-1];

    // Operand stage
    logic [XLEN-1:0]   a_r;
    logic [XLEN-1:0]   b_r;
    logic              a_signed;
    logic              b_signed;
    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic [XLEN:0]     b_ext;
    logic [2*XLEN-1:0] m1;
    logic [2*XLEN-1:0] m2;
    logic [2*XLEN-1:0] pp     [XLEN/2];
    logic [2*XLEN-1:0] corr;

    // Partial product stage
    logic [2*XLEN-1:0] pp_r   [XLEN/2];
    logic [2*XLEN-1:0] corr_r;
    logic              neg_1;
    logic [2*XLEN-1:0] l1     [12];
    logic [2*XLEN-1:0] l2     [8];

    // Tree stage
    logic [2*XLEN-1:0] t_r    [8];
    logic              neg_2;
    logic [2*XLEN-1:0] l3     [6];
    logic [2*XLEN-1:0] l4     [4];
    logic [2*XLEN-1:0] l5     [3];
    logic [2*XLEN-1:0] l6     [2];
    logic [2*XLEN-1:0] sum_final;
    logic [2*XLEN-1:0] product;
    logic [XLEN-1:0]   prod_r;

    function automatic logic [2*XLEN-1:0] csa_sum(
        input logic [2*XLEN-1:0] x,
        input logic [2*XLEN-1:0] y,
        input logic [2*XLEN-1:0] z
    );
        csa_sum = x ^ y ^ z;
    endfunction

    function automatic logic [2*XLEN-1:0] csa_carry(
        input logic [2*XLEN-1:0] x,
        input logic [2*XLEN-1:0] y,
        input logic [2*XLEN-1:0] z
    );
        csa_carry = ((x & y) | (x & z) | (y & z)) << 1;
    endfunction

    // One valid bit per pipeline stage
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vld <= '0;
        end else begin
            vld <= {vld[MUL_LATENCY-2:0], bus.start};
        end
    end

    always_ff @(posedge CLK) begin
        if (bus.start) begin
            a_r       <= bus.a;
            b_r       <= bus.b;
            mode_p[0] <= bus.mode;
            tag_p[0]  <= bus.tag;
        end
        for (int k = 1; k < MUL_LATENCY; k++) begin
            tag_p[k] <= tag_p[k-1];
        end
        for (int k = 1; k < MUL_LATENCY - 1; k++) begin
            mode_p[k] <= mode_p[k-1];
        end
    end

    // MULHU treats both operands as unsigned and MULHSU only b
    assign a_signed = (mode_p[0] != MODE_W'(MULHU));
    assign b_signed = (mode_p[0] == MODE_W'(MUL)) || (mode_p[0] == MODE_W'(MULH));
    assign a_neg    = a_signed && a_r[XLEN-1];
    assign b_neg    = b_signed && b_r[XLEN-1];
    assign a_mag    = a_neg ? -a_r : a_r;
    assign b_mag    = b_neg ? -b_r : b_r;

    assign m1    = {{XLEN{1'b0}}, a_mag};
    assign m2    = m1 << 1;
    assign b_ext = {b_mag, 1'b0};

    // Recoding reads the top bit of b_mag as a sign
    // Adding the multiplicand at weight 2^XLEN undoes that
    assign corr = b_mag[XLEN-1] ? (m1 << XLEN) : '0;

    // Radix-4 Booth digits
    always_comb begin
        for (int k = 0; k < XLEN/2; k++) begin
            case (b_ext[2*k +: 3])
                3'b001, 3'b010: pp[k] = m1 << (2*k);
                3'b011:         pp[k] = m2 << (2*k);
                3'b100:         pp[k] = (-m2) << (2*k);
                3'b101, 3'b110: pp[k] = (-m1) << (2*k);
                default:        pp[k] = '0;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        pp_r   <= pp;
        corr_r <= corr;
        neg_1  <= a_neg ^ b_neg;
    end

    // Layer 1 takes 15 products while pp15 and the correction pass straight on
    always_comb begin
        for (int g = 0; g < 5; g++) begin
            l1[2*g]   = csa_sum(pp_r[3*g], pp_r[3*g+1], pp_r[3*g+2]);
            l1[2*g+1] = csa_carry(pp_r[3*g], pp_r[3*g+1], pp_r[3*g+2]);
        end
        l1[10] = pp_r[15];
        l1[11] = corr_r;
    end

    // Layer 2 reduces twelve rows to eight
    always_comb begin
        for (int g = 0; g < 4; g++) begin
            l2[2*g]   = csa_sum(l1[3*g], l1[3*g+1], l1[3*g+2]);
            l2[2*g+1] = csa_carry(l1[3*g], l1[3*g+1], l1[3*g+2]);
        end
    end

    always_ff @(posedge CLK) begin
        t_r   <= l2;
        neg_2 <= neg_1;
    end

    // Layers 3 and 4
    always_comb begin
        for (int g = 0; g < 2; g++) begin
            l3[2*g]   = csa_sum(t_r[3*g], t_r[3*g+1], t_r[3*g+2]);
            l3[2*g+1] = csa_carry(t_r[3*g], t_r[3*g+1], t_r[3*g+2]);
        end
        l3[4] = t_r[6];
        l3[5] = t_r[7];
    end

    always_comb begin
        for (int g = 0; g < 2; g++) begin
            l4[2*g]   = csa_sum(l3[3*g], l3[3*g+1], l3[3*g+2]);
            l4[2*g+1] = csa_carry(l3[3*g], l3[3*g+1], l3[3*g+2]);
        end
    end

    // Layers 5 and 6 leave one sum and one carry row
    assign l5[0] = csa_sum(l4[0], l4[1], l4[2]);
    assign l5[1] = csa_carry(l4[0], l4[1], l4[2]);
    assign l5[2] = l4[3];
    assign l6[0] = csa_sum(l5[0], l5[1], l5[2]);
    assign l6[1] = csa_carry(l5[0], l5[1], l5[2]);

    assign sum_final = l6[0] + l6[1];
    assign product   = neg_2 ? -sum_final : sum_final;

    // Low word for MUL, high word for the others
    always_ff @(posedge CLK) begin
        if (mode_p[MUL_LATENCY-2] == MODE_W'(MUL)) begin
            prod_r <= product[XLEN-1:0];
        end else begin
            prod_r <= product[2*XLEN-1:XLEN];
        end
    end

    assign bus.done       = vld[MUL_LATENCY-1];
    assign bus.result     = prod_r;
    assign bus.result_tag = tag_p[MUL_LATENCY-1];
    assign bus.busy       = 1'b0;

endmodule

// ==== logic/exec_if.sv ====
`timescale 1ns/1ps
// Request and result bundle between the port block and one execution unit
interface exec_if import muldiv_pkg::*; ();

    // Request side
    logic              start;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [MODE_W-1:0] mode;
    logic [TAG_W-1:0]  tag;

    // Result side
    logic              done;
    logic [XLEN-1:0]   result;
    logic [TAG_W-1:0]  result_tag;
    logic              grant;
    logic              busy;

    // Port block launching requests
    modport issuer (output start, a, b, mode, tag, input busy);

    // Execution unit
    modport unit (
        input  start, a, b, mode, tag, grant,
        output done, result, result_tag, busy
    );

    // Port block collecting results
    modport arbiter (input done, result, result_tag, output grant);

endinterface

// ==== logic/muldiv_pkg.sv ====
// Shared widths, operation codes and divider constants for the multiply/divide unit
package muldiv_pkg;

    // Datapath and request field widths
    localparam int XLEN   = 32;
    localparam int TAG_W  = 4;
    localparam int OP_W   = 3;

    // Low two bits of the operation as seen by a unit
    localparam int MODE_W = 2;

    // Top bit of the operation selects the divider
    typedef enum logic [OP_W-1:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } muldiv_op_e;

    // Cycles from accepted request to multiplier done
    localparam int MUL_LATENCY = 4;

    // Shift-subtract iterations per divide
    localparam int DIV_STEPS = 32;

    // Step counter wide enough to hold DIV_STEPS itself
    localparam int DIV_CNT_W = 6;

endpackage
